/* rtl/rd_master_pkg.sv */
// Read master widths, burst limits, vector types and AR channel state encoding

package rd_master_pkg;

  //////////////////////////////////////////////////
  // Bus geometry
  //////////////////////////////////////////////////

  // Byte address width of the AXI4 master
  localparam int addr_w = 32;
  // Read data width, one beat
  localparam int data_w = 32;
  // Width of the transfer size input, in bytes
  localparam int xfer_size_w = 20;

  // Bytes carried by one beat
  localparam int bus_bytes = data_w / 8;
  localparam int log_bus_bytes = $clog2(bus_bytes);

  //////////////////////////////////////////////////
  // Burst limits
  //////////////////////////////////////////////////

  // AXI4 protocol ceilings for INCR bursts
  localparam int axi_max_burst_len = 256;
  localparam int axi_max_burst_bytes = 4096;

  // Full burst length, bounded by both the beat limit and the 4 KB boundary
  localparam int burst_len = (axi_max_burst_bytes / bus_bytes < axi_max_burst_len) ?
                             axi_max_burst_bytes / bus_bytes : axi_max_burst_len;
  localparam int log_burst_len = $clog2(burst_len);

  // Address step between consecutive bursts
  localparam int burst_bytes = burst_len * bus_bytes;

  // Bursts allowed open on the bus at once
  localparam int max_outstanding = 4;

  // Derived counter widths
  localparam int beat_cnt_w = xfer_size_w - log_bus_bytes;
  localparam int burst_cnt_w = beat_cnt_w - log_burst_len;
  localparam int arlen_w = 8;
  localparam int outstanding_w = $clog2(max_outstanding + 1);

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [xfer_size_w-1:0] xfer_size_t;
  // Beat count minus one
  typedef logic [beat_cnt_w-1:0] beat_cnt_t;
  // Burst count minus one, used as a countdown
  typedef logic [burst_cnt_w-1:0] burst_cnt_t;
  typedef logic [arlen_w-1:0] arlen_t;
  // Free burst slots, 0 up to max_outstanding
  typedef logic [outstanding_w-1:0] outstanding_t;

  // AR channel states
  // ar_idle has nothing left to issue, ar_wait holds arvalid low between bursts
  typedef enum logic [1:0] {
    ar_idle,
    ar_wait,
    ar_valid
  } ar_state_t;

endpackage

/* rtl/rd_request_setup.sv */
// Request capture with address alignment, size rounding, burst split and launch delay

`timescale 1ns/1ps

module rd_request_setup (
  input  logic                      aclk,
  input  logic                      areset,
  input  logic                      ctrl_start,
  input  rd_master_pkg::addr_t      ctrl_addr_offset,
  input  rd_master_pkg::xfer_size_t ctrl_xfer_size_in_bytes,
  output logic                      launch,
  output rd_master_pkg::addr_t      base_addr,
  output rd_master_pkg::burst_cnt_t num_bursts,
  output rd_master_pkg::arlen_t     final_len,
  output logic                      single_burst
);

  // Size in whole words, truncated
  rd_master_pkg::beat_cnt_t size_words;
  // Leftover bytes past the last whole word
  logic                     size_has_tail;
  // Rounded beat count minus one
  rd_master_pkg::beat_cnt_t total_len;
  // First stage of the launch delay
  logic                     start_d1;
  // Upper part of the beat count is the burst count minus one
  rd_master_pkg::burst_cnt_t bursts_m1;

  //////////////////////////////////////////////////
  // Size rounding
  //////////////////////////////////////////////////

  assign size_words = ctrl_xfer_size_in_bytes[rd_master_pkg::xfer_size_w-1:
                                              rd_master_pkg::log_bus_bytes];
  assign size_has_tail = |ctrl_xfer_size_in_bytes[rd_master_pkg::log_bus_bytes-1:0];

  // Capture on the strobe
  // A partial word rounds up, which cancels the minus one
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      total_len <= size_has_tail ? size_words : size_words - 1'b1;
      // Align down to the burst span so no burst crosses a 4 KB boundary
      base_addr <= ctrl_addr_offset &
                   ~rd_master_pkg::addr_t'(rd_master_pkg::burst_bytes - 1);
    end
  end

  //////////////////////////////////////////////////
  // Burst plan
  //////////////////////////////////////////////////

  assign bursts_m1 = total_len[rd_master_pkg::beat_cnt_w-1:rd_master_pkg::log_burst_len];

  // Split one cycle after capture so the plan lines up with launch
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      num_bursts   <= bursts_m1;
      // Low bits are the length of the final burst in arlen form
      final_len    <= rd_master_pkg::arlen_t'(total_len[rd_master_pkg::log_burst_len-1:0]);
      single_burst <= (bursts_m1 == '0);
    end
  end

  //////////////////////////////////////////////////
  // Launch delay
  //////////////////////////////////////////////////

  // Two flops from the strobe to launch
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      launch   <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      launch   <= start_d1;
    end
  end

endmodule

/* rtl/rd_addr_issue.sv */
// AR channel FSM with address stepping, burst countdown and outstanding-burst limit

`timescale 1ns/1ps

module rd_addr_issue (
  input  logic                      aclk,
  input  logic                      areset,
  input  logic                      launch,
  input  rd_master_pkg::addr_t      base_addr,
  input  rd_master_pkg::burst_cnt_t num_bursts,
  input  rd_master_pkg::arlen_t     final_len,
  input  logic                      single_burst,
  input  logic                      burst_closed,
  input  logic                      m_axi_arready,
  output logic                      m_axi_arvalid,
  output rd_master_pkg::addr_t      m_axi_araddr,
  output rd_master_pkg::arlen_t     m_axi_arlen
);

  rd_master_pkg::ar_state_t    state;
  rd_master_pkg::ar_state_t    state_next;
  // AR handshake this cycle
  logic                        arxfer;
  // Bursts still to issue after the current one
  rd_master_pkg::burst_cnt_t   bursts_to_go;
  // Current AR request is the final burst of the transfer
  logic                        is_last;
  // Free slots for open bursts
  rd_master_pkg::outstanding_t vacancy;
  logic                        stall_ar;
  rd_master_pkg::addr_t        addr;

  assign arxfer   = m_axi_arvalid & m_axi_arready;
  assign stall_ar = (vacancy == '0);

  //////////////////////////////////////////////////
  // AR state machine
  //////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      rd_master_pkg::ar_idle: begin
        if (launch) begin
          state_next = rd_master_pkg::ar_wait;
        end
      end
      rd_master_pkg::ar_wait: begin
        // Hold off while every burst slot is taken
        if (!stall_ar) begin
          state_next = rd_master_pkg::ar_valid;
        end
      end
      rd_master_pkg::ar_valid: begin
        if (m_axi_arready) begin
          state_next = is_last ? rd_master_pkg::ar_idle : rd_master_pkg::ar_wait;
        end
      end
      default: state_next = rd_master_pkg::ar_idle;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= rd_master_pkg::ar_idle;
    end else begin
      state <= state_next;
    end
  end

  // Valid straight from the state flop
  assign m_axi_arvalid = (state == rd_master_pkg::ar_valid);

  //////////////////////////////////////////////////
  // Address and burst countdown
  //////////////////////////////////////////////////

  // Step one burst span per accepted request
  always_ff @(posedge aclk) begin
    if (launch) begin
      addr <= base_addr;
    end else if (arxfer) begin
      addr <= addr + rd_master_pkg::addr_t'(rd_master_pkg::burst_bytes);
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_to_go <= '0;
      is_last      <= 1'b0;
    end else if (launch) begin
      bursts_to_go <= num_bursts;
      is_last      <= single_burst;
    end else if (arxfer && !is_last) begin
      bursts_to_go <= bursts_to_go - 1'b1;
      // Next request is the last one once a single burst remains
      is_last      <= (bursts_to_go == rd_master_pkg::burst_cnt_t'(1));
    end
  end

  assign m_axi_araddr = addr;
  assign m_axi_arlen  = is_last ? final_len :
                        rd_master_pkg::arlen_t'(rd_master_pkg::burst_len - 1);

  //////////////////////////////////////////////////
  // Outstanding limit
  //////////////////////////////////////////////////

  // Issue takes a slot, a closed burst gives it back
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= rd_master_pkg::outstanding_t'(rd_master_pkg::max_outstanding);
    end else begin
      case ({arxfer, burst_closed})
        2'b10:   vacancy <= vacancy - 1'b1;
        2'b01:   vacancy <= vacancy + 1'b1;
        default: vacancy <= vacancy;
      endcase
    end
  end

  // Slot count stays in range against closes reported by the data side
  assert property (@(posedge aclk) disable iff (areset)
    (vacancy <= rd_master_pkg::max_outstanding) &&
    !(stall_ar && arxfer && !burst_closed) &&
    !((vacancy == rd_master_pkg::max_outstanding) && burst_closed && !arxfer));

  // AR payload is held until accepted
  assert property (@(posedge aclk) disable iff (areset)
    (m_axi_arvalid && !m_axi_arready) |=>
      (m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen)));

endmodule

/* rtl/rd_data_track.sv */
// R channel to stream pass-through with burst completion countdown and done pulse

`timescale 1ns/1ps

module rd_data_track (
  input  logic                      aclk,
  input  logic                      areset,
  input  logic                      launch,
  input  rd_master_pkg::burst_cnt_t num_bursts,
  input  logic                      m_axi_rvalid,
  input  rd_master_pkg::data_t      m_axi_rdata,
  input  logic                      m_axi_rlast,
  input  logic                      m_axis_tready,
  output logic                      m_axi_rready,
  output logic                      m_axis_tvalid,
  output rd_master_pkg::data_t      m_axis_tdata,
  output logic                      m_axis_tlast,
  output logic                      burst_closed,
  output logic                      ctrl_done
);

  // Accepted beat
  logic                      rxfer;
  // Bursts still to complete after the current one
  rd_master_pkg::burst_cnt_t bursts_left;
  // A transfer is in flight
  logic                      active;
  logic                      final_close;

  //////////////////////////////////////////////////
  // Pass-through
  //////////////////////////////////////////////////

  // Stream back-pressure reaches the slave directly
  assign m_axi_rready  = m_axis_tready;
  assign m_axis_tvalid = m_axi_rvalid;
  assign m_axis_tdata  = m_axi_rdata;
  assign m_axis_tlast  = m_axi_rlast;

  assign rxfer        = m_axi_rvalid & m_axi_rready;
  // Last beat accepted frees one burst slot
  assign burst_closed = rxfer & m_axi_rlast;

  //////////////////////////////////////////////////
  // Completion tracking
  //////////////////////////////////////////////////

  assign final_close = burst_closed & active & (bursts_left == '0);

  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
      active      <= 1'b0;
    end else if (launch) begin
      bursts_left <= num_bursts;
      active      <= 1'b1;
    end else if (final_close) begin
      active      <= 1'b0;
    end else if (burst_closed && active) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  // Done one cycle after the closing beat
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= final_close;
    end
  end

  assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done);

endmodule

/* rtl/rd_master_top.sv */
// AXI4 read master top level joining request setup, AR issue and data tracking

`timescale 1ns/1ps

module rd_master_top (
  input  logic                      aclk,
  input  logic                      areset,

  // Control
  input  logic                      ctrl_start,
  output logic                      ctrl_done,
  input  rd_master_pkg::addr_t      ctrl_addr_offset,
  input  rd_master_pkg::xfer_size_t ctrl_xfer_size_in_bytes,

  // AXI4 read address channel
  output logic                      m_axi_arvalid,
  input  logic                      m_axi_arready,
  output rd_master_pkg::addr_t      m_axi_araddr,
  output rd_master_pkg::arlen_t     m_axi_arlen,

  // AXI4 read data channel
  input  logic                      m_axi_rvalid,
  output logic                      m_axi_rready,
  input  rd_master_pkg::data_t      m_axi_rdata,
  input  logic                      m_axi_rlast,

  // AXI4-Stream output
  output logic                      m_axis_tvalid,
  input  logic                      m_axis_tready,
  output rd_master_pkg::data_t      m_axis_tdata,
  output logic                      m_axis_tlast
);

  //////////////////////////////////////////////////
  // Burst plan shared by both channels
  //////////////////////////////////////////////////

  logic                      launch;
  rd_master_pkg::addr_t      base_addr;
  rd_master_pkg::burst_cnt_t num_bursts;
  rd_master_pkg::arlen_t     final_len;
  logic                      single_burst;
  // Data side tells the AR side a slot is free
  logic                      burst_closed;

  rd_request_setup i_rd_request_setup (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .launch                  (launch),
    .base_addr               (base_addr),
    .num_bursts              (num_bursts),
    .final_len               (final_len),
    .single_burst            (single_burst)
  );

  rd_addr_issue i_rd_addr_issue (
    .aclk          (aclk),
    .areset        (areset),
    .launch        (launch),
    .base_addr     (base_addr),
    .num_bursts    (num_bursts),
    .final_len     (final_len),
    .single_burst  (single_burst),
    .burst_closed  (burst_closed),
    .m_axi_arready (m_axi_arready),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen)
  );

  rd_data_track i_rd_data_track (
    .aclk          (aclk),
    .areset        (areset),
    .launch        (launch),
    .num_bursts    (num_bursts),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rdata   (m_axi_rdata),
    .m_axi_rlast   (m_axi_rlast),
    .m_axis_tready (m_axis_tready),
    .m_axi_rready  (m_axi_rready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .burst_closed  (burst_closed),
    .ctrl_done     (ctrl_done)
  );

endmodule

/* bench/rd_master_tb.sv */
// Read master testbench with clock, reset, AXI slave model, golden stimulus, checks and report

`timescale 1ns/1ps

module rd_master_tb;

  localparam int num_tests = 5;
  localparam int done_timeout = 20000;

  logic                      aclk;
  logic                      areset;
  logic                      ctrl_start;
  logic                      ctrl_done;
  rd_master_pkg::addr_t      ctrl_addr_offset;
  rd_master_pkg::xfer_size_t ctrl_xfer_size_in_bytes;
  logic                      m_axi_arvalid;
  logic                      m_axi_arready;
  rd_master_pkg::addr_t      m_axi_araddr;
  rd_master_pkg::arlen_t     m_axi_arlen;
  logic                      m_axi_rvalid;
  logic                      m_axi_rready;
  rd_master_pkg::data_t      m_axi_rdata;
  logic                      m_axi_rlast;
  logic                      m_axis_tvalid;
  logic                      m_axis_tready;
  rd_master_pkg::data_t      m_axis_tdata;
  logic                      m_axis_tlast;

  // Four words per test: start address, size, bursts, beats
  logic [31:0] golden [0:4*num_tests-1];

  // Expected values and observed progress of the running test
  rd_master_pkg::addr_t exp_base;
  int exp_bursts;
  int exp_beats;
  int ar_count;
  int ar_beats;
  int beat_count;
  int closed_count;
  int done_count;
  int error_count;
  int tests_passed;
  logic timed_out;

  // Slave model state
  rd_master_pkg::addr_t  ar_addr_q [$];
  rd_master_pkg::arlen_t ar_len_q [$];
  int r_beat;
  logic r_accepted;
  // Beat taken on the stream side
  logic t_accepted;
  logic [15:0] lfsr;

  // AR and done values seen at the previous edge
  logic                  arvalid_prev;
  logic                  arready_prev;
  rd_master_pkg::addr_t  araddr_prev;
  rd_master_pkg::arlen_t arlen_prev;
  logic                  done_prev;

  rd_master_top i_rd_master_top (.*);

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  //////////////////////////////////////////////////
  // Bus monitors
  //////////////////////////////////////////////////

  task automatic check_ar_hold();
    if (arvalid_prev && !arready_prev) begin
      if (!m_axi_arvalid) begin
        $display("AR valid dropped before arready was seen");
        error_count++;
      end
      if (m_axi_araddr !== araddr_prev) begin
        $display("Mismatch araddr held: expected %h, got %h", araddr_prev, m_axi_araddr);
        error_count++;
      end
      if (m_axi_arlen !== arlen_prev) begin
        $display("Mismatch arlen held: expected %h, got %h", arlen_prev, m_axi_arlen);
        error_count++;
      end
    end
  endtask

  task automatic record_ar();
    rd_master_pkg::addr_t exp_addr;
    int exp_len;
    // Bursts step by 1 KB, all full except the last
    exp_addr = exp_base + rd_master_pkg::addr_t'(1024 * ar_count);
    exp_len = (ar_count < exp_bursts - 1) ? 255 : exp_beats - 256 * (exp_bursts - 1) - 1;
    if (ar_count >= exp_bursts) begin
      $display("AR request beyond the expected burst count");
      error_count++;
    end
    if (m_axi_araddr !== exp_addr) begin
      $display("Mismatch araddr: expected %h, got %h", exp_addr, m_axi_araddr);
      error_count++;
    end
    if (int'(m_axi_arlen) != exp_len) begin
      $display("Mismatch arlen: expected %h, got %h", exp_len, m_axi_arlen);
      error_count++;
    end
    ar_addr_q.push_back(m_axi_araddr);
    ar_len_q.push_back(m_axi_arlen);
    ar_count++;
    ar_beats += int'(m_axi_arlen) + 1;
    if (ar_count - closed_count > 4) begin
      $display("More than four bursts open at once");
      error_count++;
    end
  endtask

  task automatic record_beat();
    rd_master_pkg::data_t exp_data;
    logic exp_last;
    exp_data = rd_master_pkg::data_t'(exp_base + rd_master_pkg::addr_t'(4 * beat_count));
    exp_last = ((beat_count % 256) == 255) || (beat_count == exp_beats - 1);
    if (beat_count >= exp_beats) begin
      $display("Stream beat beyond the expected beat count");
      error_count++;
    end
    if (m_axis_tdata !== exp_data) begin
      $display("Mismatch tdata: expected %h, got %h", exp_data, m_axis_tdata);
      error_count++;
    end
    if (m_axis_tlast !== exp_last) begin
      $display("Mismatch tlast: expected %h, got %h", exp_last, m_axis_tlast);
      error_count++;
    end
    beat_count++;
    if (m_axis_tlast) closed_count++;
  endtask

  // Slave moves to the next beat or the next queued burst
  task automatic advance_slave();
    if (r_beat == int'(ar_len_q[0])) begin
      void'(ar_addr_q.pop_front());
      void'(ar_len_q.pop_front());
      r_beat = 0;
    end else begin
      r_beat++;
    end
  endtask

  task automatic record_done();
    done_count++;
    if (done_prev) begin
      $display("ctrl_done stayed high for more than one cycle");
      error_count++;
    end
    if (beat_count != exp_beats) begin
      $display("ctrl_done arrived before the final beat was accepted");
      error_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // AXI slave model
  //////////////////////////////////////////////////

  task automatic drive_slave();
    lfsr = lfsr_next(lfsr);
    // Queue holds at most 8 requests
    m_axi_arready = lfsr[0] && (ar_addr_q.size() < 8);
    lfsr = lfsr_next(lfsr);
    m_axis_tready = lfsr[0];
    // A pending beat stays on the bus until accepted
    if (!m_axi_rvalid || r_accepted) begin
      if (ar_addr_q.size() > 0) begin
        lfsr = lfsr_next(lfsr);
        m_axi_rvalid = lfsr[0];
        m_axi_rdata  = ar_addr_q[0] + rd_master_pkg::addr_t'(4 * r_beat);
        m_axi_rlast  = (r_beat == int'(ar_len_q[0]));
      end else begin
        m_axi_rvalid = 1'b0;
        m_axi_rlast  = 1'b0;
      end
    end
  endtask

  // Sample at the edge, drive 1 ns later
  always begin
    @(posedge aclk);
    r_accepted = m_axi_rvalid && m_axi_rready;
    t_accepted = m_axis_tvalid && m_axis_tready;
    if (!areset) begin
      check_ar_hold();
      if (ctrl_done) record_done();
      if (m_axi_arvalid && m_axi_arready) record_ar();
      // Pass-through, so a beat is taken on both sides in the same cycle
      if (t_accepted !== r_accepted) begin
        $display("Mismatch stream handshake: expected %h, got %h", r_accepted, t_accepted);
        error_count++;
      end
      if (t_accepted) record_beat();
      if (r_accepted) advance_slave();
    end
    arvalid_prev = m_axi_arvalid;
    arready_prev = m_axi_arready;
    araddr_prev  = m_axi_araddr;
    arlen_prev   = m_axi_arlen;
    done_prev    = ctrl_done;
    #1;
    drive_slave();
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  task automatic run_test(input int idx);
    rd_master_pkg::addr_t start_addr;
    int size;
    int errors_before;
    int cycles;
    start_addr = golden[4*idx];
    size = int'(golden[4*idx+1]);
    exp_bursts = int'(golden[4*idx+2]);
    exp_beats = int'(golden[4*idx+3]);
    errors_before = error_count;
    // Align down to the 1 KB burst span
    exp_base = start_addr & ~32'h3ff;
    // Golden counts against the rounding rule
    if (exp_beats != (size + 3) / 4 || exp_bursts != (exp_beats + 255) / 256) begin
      $display("Golden line %0d disagrees with the size rounding rule", idx);
      error_count++;
    end
    ar_count = 0;
    ar_beats = 0;
    beat_count = 0;
    closed_count = 0;
    done_count = 0;
    @(posedge aclk);
    #1;
    ctrl_addr_offset = start_addr;
    ctrl_xfer_size_in_bytes = rd_master_pkg::xfer_size_t'(size);
    ctrl_start = 1'b1;
    @(posedge aclk);
    #1;
    ctrl_start = 1'b0;
    cycles = 0;
    while (done_count == 0 && cycles < done_timeout) begin
      @(posedge aclk);
      #1;
      cycles++;
    end
    if (done_count == 0) begin
      $display("Test %0d timed out after %0d cycles without ctrl_done", idx, done_timeout);
      error_count++;
      timed_out = 1'b1;
    end else begin
      // Quiet cycles catch a second done pulse
      repeat (4) begin
        @(posedge aclk);
        #1;
      end
      if (ar_count != exp_bursts) begin
        $display("Mismatch AR count: expected %h, got %h", exp_bursts, ar_count);
        error_count++;
      end
      if (ar_beats != exp_beats || beat_count != exp_beats) begin
        $display("Mismatch beats: expected %h, got %h requested, %h streamed",
                 exp_beats, ar_beats, beat_count);
        error_count++;
      end
      if (done_count != 1) begin
        $display("ctrl_done pulsed %0d times instead of once", done_count);
        error_count++;
      end
    end
    if (error_count == errors_before) tests_passed++;
    $display("Test %0d addr %h size %0d: %s", idx, start_addr, size,
             (error_count == errors_before) ? "ok" : "failed");
  endtask

  initial begin
    int i;
    areset = 1'b1;
    ctrl_start = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_xfer_size_in_bytes = '0;
    m_axi_arready = 1'b0;
    m_axi_rvalid = 1'b0;
    m_axi_rdata = '0;
    m_axi_rlast = 1'b0;
    m_axis_tready = 1'b0;
    lfsr = 16'd38;
    r_beat = 0;
    error_count = 0;
    tests_passed = 0;
    timed_out = 1'b0;
    $readmemh("bench/rd_master_golden.txt", golden);
    repeat (8) @(posedge aclk);
    #1;
    areset = 1'b0;
    for (i = 0; i < num_tests && !timed_out; i++) begin
      run_test(i);
    end
    $display("Tests run %0d, passed %0d, errors %0d", i, tests_passed, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* bench/rd_master_golden.txt */
// Columns in hex: start_addr size_bytes bursts beats
// One line per test
00001234 00000004 00000001 00000001
00020010 00000064 00000001 00000019
00003c00 00000400 00000001 00000100
000047ff 00000401 00000002 00000101
00100000 00001388 00000005 000004e2

/* verilog.f */
rtl/rd_master_pkg.sv
rtl/rd_request_setup.sv
rtl/rd_addr_issue.sv
rtl/rd_data_track.sv
rtl/rd_master_top.sv
bench/rd_master_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the read master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module rd_master_tb -f verilog.f -o rd_master_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/rd_master_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log

grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
